// ==== flist.f ====
source/stepper_pkg.sv
source/spi_word.sv
source/spi_command_decoder.sv
source/dda_timer.sv
source/stepper_controller.sv
test/stepper_controller_asserts.sv
test/stepper_controller_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; success only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
  --top-module stepper_controller_tb -f flist.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "Test OK" && exit 0 || exit 1

// ==== test/stepper_controller_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_controller_tb
  import stepper_pkg::*;
;

  localparam int MOTORS = 2;
  localparam int N_TESTS = 12;
  localparam int HALF = 4;
  localparam int FRAME_CYCLES = 1 + WORD_BITS * 2 * HALF + 3 * HALF;
  localparam int SETTLE = 20;
  localparam logic [31:0] SEED = 32'h87cf_aaf7;

  typedef enum logic [2:0] {k_reset, k_config, k_version, k_move, k_pair} kind_t;

  typedef struct packed {
    kind_t      kind;
    word_t      word;
    logic [1:0] exp_enable;
    logic [2:0] exp_micro;
    logic [7:0] exp_current;
    word_t      duration;
    logic [1:0] dirs;
  } entry_t;

  logic CLK;
  logic resetn;
  logic sck;
  logic cs;
  logic copi;
  logic cipo;
  word_t encoder_count;
  logic [MOTORS-1:0] step;
  logic [MOTORS-1:0] dir;
  logic [MOTORS-1:0] enable;
  logic [2:0] microsteps;
  logic [7:0] current;
  logic buffer_ready;
  logic move_done;

  entry_t tbl [N_TESTS];
  string names [N_TESTS];
  logic [31:0] lfsr;
  int errors = 0;
  int checks = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int moves_done = 0;
  int done_read = 0;
  int run_steps [MOTORS];
  int expect_log [$];
  int done_log [$];
  logic ready_sample = 1'b0;

  stepper_controller #(
    .motor_count (MOTORS)
  ) uut (
    .CLK           (CLK),
    .resetn        (resetn),
    .sck           (sck),
    .cs            (cs),
    .copi          (copi),
    .cipo          (cipo),
    .encoder_count (encoder_count),
    .step          (step),
    .dir           (dir),
    .enable        (enable),
    .microsteps    (microsteps),
    .current       (current),
    .buffer_ready  (buffer_ready),
    .move_done     (move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles waiting for the DUT", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // Step and move_done monitor with one record per finished move
  always @(negedge CLK) begin
    ready_sample = buffer_ready;
    if (resetn) begin
      for (int m = 0; m < MOTORS; m++) begin
        if (step[m]) run_steps[m]++;
      end
      if (move_done) begin
        for (int m = 0; m < MOTORS; m++) begin
          done_log.push_back(run_steps[m]);
          run_steps[m] = 0;
        end
        done_log.push_back(int'(dir));
        moves_done++;
      end
    end
  end

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic word_t take_bits(int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[WORD_BITS-2:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic word_t signed_draw(int bits);
    word_t mag;
    mag = take_bits(bits);
    if (take_bits(1) == 64'd1) return -mag;
    return mag;
  endfunction

  // Count changes of bit 32 over the move
  function automatic int model_steps(word_t duration, word_t inc, word_t inc_inc);
    word_t acc;
    word_t nxt;
    word_t vel;
    int n;
    acc = '0;
    vel = inc;
    n = 0;
    for (longint t = 0; t < longint'(duration); t++) begin
      nxt = acc + vel;
      if (nxt[32] != acc[32]) n++;
      acc = nxt;
      vel = vel + inc_inc;
    end
    return n;
  endfunction

  // Major in 23:16, minor in 15:8, patch in 7:0
  function automatic word_t version_reply();
    word_t v;
    v = '0;
    v[23:16] = VERSION_MAJOR;
    v[15:8] = VERSION_MINOR;
    v[7:0] = VERSION_PATCH;
    return v;
  endfunction

  function automatic entry_t entry(kind_t kind, word_t word, logic [1:0] en,
                                   logic [2:0] mi, logic [7:0] cur, word_t dur,
                                   logic [1:0] dirs);
    entry_t e;
    e.kind = kind;
    e.word = word;
    e.exp_enable = en;
    e.exp_micro = mi;
    e.exp_current = cur;
    e.duration = dur;
    e.dirs = dirs;
    return e;
  endfunction

  task automatic fill_table();
    names[0] = "reset";
    tbl[0] = entry(k_reset, '0, 2'd0, 3'd2, 8'd140, '0, 2'b00);
    names[1] = "divisor_3";
    tbl[1] = entry(k_config, {CMD_CLK_DIVISOR, 56'd3}, 2'd0, 3'd2, 8'd140, '0, 2'b00);
    names[2] = "enable_both";
    tbl[2] = entry(k_config, {CMD_MOTOR_ENABLE, 56'd3}, 2'd3, 3'd2, 8'd140, '0, 2'b00);
    names[3] = "motorconfig";
    tbl[3] = entry(k_config, {CMD_MOTORCONFIG, 56'h5A05}, 2'd3, 3'd5, 8'h5A, '0, 2'b00);
    names[4] = "version";
    tbl[4] = entry(k_version, {CMD_API_VERSION, 56'd0}, 2'd3, 3'd5, 8'h5A, '0, 2'b00);
    names[5] = "move_fwd";
    tbl[5] = entry(k_move, '0, 2'd3, 3'd5, 8'h5A, 64'd40, 2'b01);
    names[6] = "move_rev";
    tbl[6] = entry(k_move, '0, 2'd3, 3'd5, 8'h5A, 64'd25, 2'b10);
    names[7] = "divisor_zero";
    tbl[7] = entry(k_config, {CMD_CLK_DIVISOR, 56'd0}, 2'd3, 3'd5, 8'h5A, '0, 2'b00);
    names[8] = "move_fast";
    tbl[8] = entry(k_move, '0, 2'd3, 3'd5, 8'h5A, 64'd60, 2'b11);
    names[9] = "divisor_200";
    tbl[9] = entry(k_config, {CMD_CLK_DIVISOR, 56'd200}, 2'd3, 3'd5, 8'h5A, '0, 2'b00);
    names[10] = "move_pair";
    tbl[10] = entry(k_pair, '0, 2'd3, 3'd5, 8'h5A, 64'd40, 2'b00);
    names[11] = "enable_one";
    tbl[11] = entry(k_config, {CMD_MOTOR_ENABLE, 56'd1}, 2'd1, 3'd5, 8'h5A, '0, 2'b00);
  endtask

  // Frames plus move playback at the divisor in force plus margin
  function automatic int run_limit();
    int cycles;
    int div;
    cycles = 16 + 2000;
    div = 40;
    for (int i = 0; i < N_TESTS; i++) begin
      case (tbl[i].kind)
        k_config: begin
          cycles += FRAME_CYCLES;
          if (tbl[i].word[63:56] == CMD_CLK_DIVISOR) begin
            div = (tbl[i].word[7:0] == 8'd0) ? 1 : int'(tbl[i].word[7:0]);
          end
        end
        k_version: cycles += 2 * FRAME_CYCLES;
        k_move: cycles += (2 + 2 * MOTORS) * FRAME_CYCLES + int'(tbl[i].duration) * div + 100;
        k_pair: cycles += (4 + 4 * MOTORS) * FRAME_CYCLES + 2 * int'(tbl[i].duration) * div + 200;
        default: cycles += 100;
      endcase
    end
    return cycles;
  endfunction

  // Mode 0 host sets data on the falling SCK edge and samples the reply before the rising one
  task automatic spi_frame(input word_t mosi, output word_t miso);
    @(posedge CLK);
    cs <= 1'b0;
    for (int i = WORD_BITS - 1; i >= 0; i--) begin
      copi <= mosi[i];
      repeat (HALF - 1) @(posedge CLK);
      @(negedge CLK);
      miso[i] = cipo;
      @(posedge CLK);
      sck <= 1'b1;
      repeat (HALF) @(posedge CLK);
      sck <= 1'b0;
    end
    repeat (HALF) @(posedge CLK);
    cs <= 1'b1;
    repeat (2 * HALF) @(posedge CLK);
  endtask

  task automatic send_move(input string name, input word_t duration, input logic [1:0] dirs);
    word_t inc [MOTORS];
    word_t inc_inc [MOTORS];
    word_t enc;
    word_t reply;
    enc = take_bits(48);
    for (int m = 0; m < MOTORS; m++) begin
      inc[m] = signed_draw(31);
      inc_inc[m] = signed_draw(22);
      expect_log.push_back(model_steps(duration, inc[m], inc_inc[m]));
    end
    expect_log.push_back(int'(dirs));
    @(posedge CLK);
    encoder_count <= enc;
    spi_frame({CMD_COORDINATED_STEP, 56'(dirs)}, reply);
    // Encoder moves on so the reply must still be the snapshot
    @(posedge CLK);
    encoder_count <= ~enc;
    spi_frame(duration, reply);
    for (int m = 0; m < MOTORS; m++) begin
      spi_frame(inc[m], reply);
      spi_frame(inc_inc[m], reply);
      checks++;
      if (reply !== enc) begin
        errors++;
        $display("Error %s: encoder reply expected %h actual %h", name, enc, reply);
      end
    end
  endtask

  task automatic check_moves(input string name, input int n);
    int exp_v;
    int act_v;
    int field;
    for (int k = 0; k < n * (MOTORS + 1); k++) begin
      field = k % (MOTORS + 1);
      exp_v = expect_log.pop_front();
      act_v = done_log[done_read];
      done_read++;
      checks++;
      if (exp_v != act_v) begin
        errors++;
        if (field < MOTORS) begin
          $display("Error %s: steps of motor %0d expected %0d actual %0d",
                   name, field, exp_v, act_v);
        end else begin
          $display("Error %s: dir expected %b actual %b", name, exp_v[1:0], act_v[1:0]);
        end
      end
    end
  endtask

  initial begin
    word_t reply;
    word_t exp_reply;
    int target;
    logic ready_early;
    resetn = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    encoder_count = '0;
    lfsr = SEED;
    for (int m = 0; m < MOTORS; m++) run_steps[m] = 0;
    fill_table();
    cycle_limit = run_limit();
    repeat (16) @(posedge CLK);
    resetn <= 1'b1;
    repeat (4) @(posedge CLK);

    for (int i = 0; i < N_TESTS; i++) begin
      case (tbl[i].kind)
        k_reset: begin
          @(negedge CLK);
          checks++;
          if (buffer_ready !== 1'b1) begin
            errors++;
            $display("Error %s: buffer_ready expected 1 actual %b", names[i], buffer_ready);
          end
          if (step !== '0) begin
            errors++;
            $display("Error %s: step expected %b actual %b", names[i], 2'b00, step);
          end
          if (dir !== '0) begin
            errors++;
            $display("Error %s: dir expected %b actual %b", names[i], 2'b00, dir);
          end
          if (move_done !== 1'b0) begin
            errors++;
            $display("Error %s: move_done expected 0 actual %b", names[i], move_done);
          end
        end
        k_config: begin
          spi_frame(tbl[i].word, reply);
        end
        k_version: begin
          exp_reply = version_reply();
          spi_frame(tbl[i].word, reply);
          spi_frame('0, reply);
          checks++;
          if (reply !== exp_reply) begin
            errors++;
            $display("Error %s: reply expected %h actual %h", names[i], exp_reply, reply);
          end
        end
        k_move: begin
          target = moves_done + 1;
          send_move(names[i], tbl[i].duration, tbl[i].dirs);
          while (moves_done < target) @(posedge CLK);
          repeat (SETTLE) @(posedge CLK);
          checks++;
          if (moves_done != target) begin
            errors++;
            $display("%s: move_done pulsed more than once", names[i]);
          end
          check_moves(names[i], 1);
        end
        k_pair: begin
          target = moves_done + 1;
          ready_early = 1'b0;
          send_move(names[i], tbl[i].duration, tbl[i].dirs);
          send_move(names[i], tbl[i].duration, ~tbl[i].dirs);
          @(posedge CLK);
          // Both slots hold a move until the first one finishes
          while (moves_done < target) begin
            if (ready_sample) ready_early = 1'b1;
            @(posedge CLK);
          end
          checks++;
          if (ready_early) begin
            errors++;
            $display("%s: buffer_ready rose before the first move finished", names[i]);
          end
          @(posedge CLK);
          checks++;
          if (!ready_sample) begin
            errors++;
            $display("%s: buffer_ready stayed low after the first move", names[i]);
          end
          while (moves_done < target + 1) @(posedge CLK);
          repeat (SETTLE) @(posedge CLK);
          check_moves(names[i], 2);
        end
        default: begin
          errors++;
          $display("%s: unknown table entry", names[i]);
        end
      endcase

      @(negedge CLK);
      checks++;
      if (enable !== tbl[i].exp_enable) begin
        errors++;
        $display("Error %s: enable expected %b actual %b", names[i], tbl[i].exp_enable, enable);
      end
      if (microsteps !== tbl[i].exp_micro) begin
        errors++;
        $display("Error %s: microsteps expected %0d actual %0d", names[i],
                 tbl[i].exp_micro, microsteps);
      end
      if (current !== tbl[i].exp_current) begin
        errors++;
        $display("Error %s: current expected %0d actual %0d", names[i],
                 tbl[i].exp_current, current);
      end
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/stepper_controller_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_controller_asserts
  import stepper_pkg::*;
(
  input logic       CLK,
  input logic       resetn,
  input logic       cs,
  input logic       word_valid,
  input word_t      tx_word,
  input logic [1:0] slot_ready,
  input logic       buffer_ready
);

  // A received word is announced for one cycle only
  assert property (@(posedge CLK) disable iff (!resetn)
    word_valid |=> !word_valid)
    else $error("word_valid held for more than one cycle");

  // A slot is committed only while the write slot was free
  assert property (@(posedge CLK) disable iff (!resetn)
    (slot_ready != $past(slot_ready)) |-> $past(buffer_ready))
    else $error("slot_ready toggled while buffer_ready was low");

  // Reply latched after the CS synchronizer is the word prepared before CS fell
  assert property (@(posedge CLK) disable iff (!resetn)
    ($past(cs, 3) && !$past(cs, 2)) |-> (tx_word == $past(tx_word, 3)))
    else $error("tx_word changed between CS fall and the reply latch");

endmodule

bind stepper_controller stepper_controller_asserts u_asserts (
  .CLK          (CLK),
  .resetn       (resetn),
  .cs           (cs),
  .word_valid   (word_valid),
  .tx_word      (tx_word),
  .slot_ready   (slot_ready),
  .buffer_ready (buffer_ready)
);

`default_nettype wire

// ==== source/stepper_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_controller
  import stepper_pkg::*;
#(
  parameter int motor_count = 2
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   sck,
  input  logic                   cs,
  input  logic                   copi,
  output logic                   cipo,
  input  word_t                  encoder_count,
  output logic [motor_count-1:0] step,
  output logic [motor_count-1:0] dir,
  output logic [motor_count-1:0] enable,
  output logic [2:0]             microsteps,
  output logic [7:0]             current,
  output logic                   buffer_ready,
  output logic                   move_done
);

  word_t tx_word;
  word_t rx_word;
  logic word_valid;
  divisor_t clock_divisor;
  divisor_t div_count;
  divisor_t div_last;
  logic tick;
  logic write_slot;
  logic read_slot;
  logic [1:0] slot_ready;
  logic [1:0] slot_done;
  logic slot_full;
  logic busy;
  logic start;
  word_t move_duration;
  motor_move_t [motor_count-1:0] motor_moves;
  logic [motor_count-1:0] dda_done;

  spi_word u_spi_word (
    .CLK        (CLK),
    .resetn     (resetn),
    .sck        (sck),
    .cs         (cs),
    .copi       (copi),
    .cipo       (cipo),
    .tx_word    (tx_word),
    .rx_word    (rx_word),
    .word_valid (word_valid)
  );

  spi_command_decoder #(
    .motor_count (motor_count)
  ) u_decoder (
    .CLK           (CLK),
    .resetn        (resetn),
    .word_valid    (word_valid),
    .rx_word       (rx_word),
    .tx_word       (tx_word),
    .encoder_count (encoder_count),
    .enable        (enable),
    .microsteps    (microsteps),
    .current       (current),
    .clock_divisor (clock_divisor),
    .write_slot    (write_slot),
    .slot_ready    (slot_ready),
    .slot_done     (slot_done),
    .read_slot     (read_slot),
    .buffer_ready  (buffer_ready),
    .move_duration (move_duration),
    .motor_moves   (motor_moves)
  );

  // Shared tick, divisor of zero behaves as one
  assign div_last = (clock_divisor == '0) ? '0 : clock_divisor - 8'd1;
  assign tick = div_count >= div_last;

  always_ff @(posedge CLK) begin
    if (!resetn || tick) begin
      div_count <= '0;
    end else begin
      div_count <= div_count + 8'd1;
    end
  end

  // All motors finish together, DDA 0 speaks for the group
  assign move_done = dda_done[0];
  assign slot_full = slot_ready[read_slot] != slot_done[read_slot];
  assign start = slot_full & ~busy;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy <= 1'b0;
      read_slot <= 1'b0;
      slot_done <= '0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (move_done) begin
      // Hand the slot back to the decoder
      busy <= 1'b0;
      slot_done[read_slot] <= ~slot_done[read_slot];
      read_slot <= ~read_slot;
    end
  end

  for (genvar m = 0; m < motor_count; m++) begin : g_motor
    dda_timer u_dda (
      .CLK       (CLK),
      .resetn    (resetn),
      .tick      (tick),
      .start     (start),
      .duration  (move_duration),
      .move      (motor_moves[m]),
      .step      (step[m]),
      .dir       (dir[m]),
      .move_done (dda_done[m])
    );
  end

endmodule

`default_nettype wire

// ==== source/dda_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dda_timer
  import stepper_pkg::*;
(
  input  logic        CLK,
  input  logic        resetn,
  input  logic        tick,
  input  logic        start,
  input  word_t       duration,
  input  motor_move_t move,
  output logic        step,
  output logic        dir,
  output logic        move_done
);

  // One full step per unit of the upper half
  localparam int step_bit = 32;

  logic busy;
  logic last_tick;
  word_t tick_count;
  word_t tick_next;
  word_t duration_q;
  logic signed [WORD_BITS-1:0] accum;
  logic signed [WORD_BITS-1:0] accum_next;
  logic signed [WORD_BITS-1:0] increment;
  logic signed [WORD_BITS-1:0] increment_increment;

  assign accum_next = accum + increment;
  assign tick_next = tick_count + 1'b1;

  // Zero duration ends after a single tick
  assign last_tick = tick_next >= duration_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy <= 1'b0;
      step <= 1'b0;
      dir <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step <= 1'b0;
      move_done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        dir <= move.dir;
      end else if (busy && tick) begin
        // A change of the step bit in either direction is one step
        step <= accum_next[step_bit] ^ accum[step_bit];
        if (last_tick) begin
          busy <= 1'b0;
          move_done <= 1'b1;
        end
      end
    end
  end

  // Accumulator and velocity
  always_ff @(posedge CLK) begin
    if (start) begin
      accum <= '0;
      tick_count <= '0;
      increment <= move.increment;
      increment_increment <= move.increment_increment;
      duration_q <= duration;
    end else if (busy && tick) begin
      accum <= accum_next;
      increment <= increment + increment_increment;
      tick_count <= tick_next;
    end
  end

endmodule

`default_nettype wire

// ==== source/spi_command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_command_decoder
  import stepper_pkg::*;
#(
  parameter int motor_count = 2
) (
  input  logic                          CLK,
  input  logic                          resetn,
  input  logic                          word_valid,
  input  word_t                         rx_word,
  output word_t                         tx_word,
  input  word_t                         encoder_count,
  output logic [motor_count-1:0]        enable,
  output logic [2:0]                    microsteps,
  output logic [7:0]                    current,
  output divisor_t                      clock_divisor,
  output logic                          write_slot,
  output logic [1:0]                    slot_ready,
  input  logic [1:0]                    slot_done,
  input  logic                          read_slot,
  output logic                          buffer_ready,
  output word_t                         move_duration,
  output motor_move_t [motor_count-1:0] motor_moves
);

  // Duration word, then increment and increment_increment per motor
  localparam logic [7:0] last_word = 8'(2 * motor_count);

  typedef enum logic [1:0] {
    msg_idle,
    msg_move,
    msg_version
  } msg_state_t;

  msg_state_t msg_state;
  logic [7:0] word_count;
  logic move_drop;
  cmd_t header_cmd;
  logic header_move;
  logic move_write;
  word_t encoder_store;

  // Two slot move buffer
  word_t duration_mem [2];
  motor_move_t [motor_count-1:0] moves_mem [2];

  assign header_cmd = rx_word[WORD_BITS-1 -: CMD_BITS];

  // Slot is free while its toggles agree
  assign buffer_ready = slot_ready[write_slot] == slot_done[write_slot];

  assign header_move = word_valid && (msg_state == msg_idle) &&
                       (header_cmd == CMD_COORDINATED_STEP) && buffer_ready;
  assign move_write = word_valid && (msg_state == msg_move) && !move_drop;

  // Playback side sees the slot at read_slot
  assign move_duration = duration_mem[read_slot];
  assign motor_moves = moves_mem[read_slot];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      msg_state <= msg_idle;
      word_count <= '0;
      move_drop <= 1'b0;
      tx_word <= '0;
      enable <= '0;
      microsteps <= DEFAULT_MICROSTEPS;
      current <= DEFAULT_CURRENT;
      clock_divisor <= DEFAULT_DIVISOR;
      write_slot <= 1'b0;
      slot_ready <= '0;
    end else if (word_valid) begin
      case (msg_state)
        msg_idle: begin
          tx_word <= '0;
          word_count <= '0;
          case (header_cmd)
            CMD_COORDINATED_STEP: begin
              // Full buffer, swallow the whole message
              move_drop <= !buffer_ready;
              msg_state <= msg_move;
            end
            CMD_MOTOR_ENABLE: begin
              enable <= rx_word[motor_count-1:0];
            end
            CMD_CLK_DIVISOR: begin
              clock_divisor <= rx_word[7:0];
            end
            CMD_MOTORCONFIG: begin
              microsteps <= rx_word[2:0];
              current <= rx_word[15:8];
            end
            CMD_API_VERSION: begin
              tx_word <= word_t'({VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH});
              msg_state <= msg_version;
            end
            default: begin
              tx_word <= '0;
            end
          endcase
        end

        msg_version: begin
          // Dummy word that carried the version out
          tx_word <= '0;
          msg_state <= msg_idle;
        end

        msg_move: begin
          word_count <= word_count + 8'd1;
          // Odd counts are increment words
          if (word_count[0] && !move_drop) begin
            tx_word <= encoder_store;
          end else begin
            tx_word <= '0;
          end
          if (word_count == last_word) begin
            msg_state <= msg_idle;
            tx_word <= '0;
            if (!move_drop) begin
              slot_ready[write_slot] <= ~slot_ready[write_slot];
              write_slot <= ~write_slot;
            end
          end
        end

        default: begin
          msg_state <= msg_idle;
        end
      endcase
    end
  end

  // Move records and encoder snapshot
  always_ff @(posedge CLK) begin
    if (header_move) begin
      encoder_store <= encoder_count;
      for (int m = 0; m < motor_count; m++) begin
        moves_mem[write_slot][m].dir <= rx_word[m];
      end
    end
    if (move_write) begin
      if (word_count == 8'd0) begin
        duration_mem[write_slot] <= rx_word;
      end
      for (int m = 0; m < motor_count; m++) begin
        if (word_count == 8'(2 * m + 1)) begin
          moves_mem[write_slot][m].increment <= rx_word;
        end
        if (word_count == 8'(2 * m + 2)) begin
          moves_mem[write_slot][m].increment_increment <= rx_word;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/spi_word.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_word
  import stepper_pkg::*;
(
  input  logic  CLK,
  input  logic  resetn,
  input  logic  sck,
  input  logic  cs,
  input  logic  copi,
  output logic  cipo,
  input  word_t tx_word,
  output word_t rx_word,
  output logic  word_valid
);

  localparam int count_bits = $clog2(WORD_BITS);
  typedef logic [count_bits-1:0] count_t;
  localparam count_t last_bit = count_t'(WORD_BITS - 1);

  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;
  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_rise;
  logic frame_active;
  count_t bit_count;
  word_t rx_shift;
  word_t rx_next;
  word_t tx_shift;

  // Two flops of synchronizer, third stage for edge detection
  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign cs_fall = ~cs_sync[1] & cs_sync[2];
  assign cs_rise = cs_sync[1] & ~cs_sync[2];
  assign frame_active = ~cs_sync[1];

  assign rx_next = {rx_shift[WORD_BITS-2:0], copi_sync[1]};
  assign cipo = tx_shift[WORD_BITS-1];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_sync <= '0;
      cs_sync <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      cs_sync <= {cs_sync[1:0], cs};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count <= '0;
      tx_shift <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_fall) begin
        // Reply word is latched at the start of the frame
        tx_shift <= tx_word;
        bit_count <= '0;
      end else if (cs_rise) begin
        // Short frame, partial word is dropped
        bit_count <= '0;
      end else if (frame_active) begin
        if (sck_rise) begin
          bit_count <= bit_count + 1'b1;
          if (bit_count == last_bit) begin
            word_valid <= 1'b1;
          end
        end
        if (sck_fall) begin
          tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b0};
        end
      end
    end
  end

  // Receive shifter, MSB first
  always_ff @(posedge CLK) begin
    if (frame_active && !cs_fall && sck_rise) begin
      rx_shift <= rx_next;
      if (bit_count == last_bit) begin
        rx_word <= rx_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/stepper_pkg.sv ====
`default_nettype none

package stepper_pkg;

  // Word and header widths on the SPI link
  localparam int WORD_BITS = 64;
  localparam int CMD_BITS = 8;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [CMD_BITS-1:0] cmd_t;
  typedef logic [7:0] divisor_t;

  // Header codes, top byte of the first word of a message
  localparam cmd_t CMD_COORDINATED_STEP = 8'h01;
  localparam cmd_t CMD_MOTOR_ENABLE = 8'h0A;
  localparam cmd_t CMD_CLK_DIVISOR = 8'h0B;
  localparam cmd_t CMD_MOTORCONFIG = 8'h10;
  localparam cmd_t CMD_API_VERSION = 8'hFE;

  // API version reported to the host
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd3;
  localparam logic [7:0] VERSION_PATCH = 8'd1;

  // Configuration after reset
  localparam logic [2:0] DEFAULT_MICROSTEPS = 3'd2;
  localparam logic [7:0] DEFAULT_CURRENT = 8'd140;
  // 400 kHz ticks from a 16 MHz clock
  localparam divisor_t DEFAULT_DIVISOR = 8'd40;

  // One motor's share of a coordinated move
  typedef struct packed {
    logic signed [WORD_BITS-1:0] increment;
    logic signed [WORD_BITS-1:0] increment_increment;
    logic dir;
  } motor_move_t;

endpackage

`default_nettype wire
